//--- common/cuPkg.sv
/*
 * Control unit package: widths, SPARC v8 opcode field values,
 * trap types and the structs passed between the control blocks
 */
package cuPkg;
        localparam int AddrWidth  = 32;
        localparam int DataWidth  = 32;
        localparam int NumWindows = 8;
        localparam logic [AddrWidth-1:0] AddrLimit = 32'd508; // highest legal target

        typedef logic [$clog2(NumWindows)-1:0] cwpT;

        // same bit order as PSR[23:20]
        typedef struct packed {
                logic n;
                logic z;
                logic v;
                logic c;
        } iccT;

        typedef enum logic [3:0] {
                Branch, Call, Save, Restore, Ticc, WrPsr, WrWim, WrTbr, Illegal
        } instrClassT;

        typedef logic [7:0] trapT;
        localparam trapT TtNone     = 8'h00;
        localparam trapT TtIllegal  = 8'h02;
        localparam trapT TtWinOver  = 8'h05;
        localparam trapT TtWinUnder = 8'h06;
        localparam trapT TtAddr     = 8'h07;
        localparam trapT TtTicc     = 8'h80; // plus software trap number

        localparam logic [1:0] OpBranch   = 2'd0;
        localparam logic [1:0] OpCall     = 2'd1;
        localparam logic [1:0] OpArith    = 2'd2;
        localparam logic [2:0] Op2Bicc    = 3'd2;
        localparam logic [5:0] Op3Save    = 6'h3C;
        localparam logic [5:0] Op3Restore = 6'h3D;
        localparam logic [5:0] Op3Ticc    = 6'h3A;
        localparam logic [5:0] Op3WrPsr   = 6'h31;
        localparam logic [5:0] Op3WrWim   = 6'h32;
        localparam logic [5:0] Op3WrTbr   = 6'h33;

        typedef struct packed {
                instrClassT        instrClass;
                logic              condTrue;
                logic signed [29:0] disp;   // word displacement
                logic [12:0]       imm;
        } decodedT;

        typedef struct packed {
                logic [AddrWidth-1:0] pc;
                instrClassT           instrClass;
                logic                 taken;
                trapT                 tt;
                cwpT                  cwp;   // window after the instruction
        } retireT;

        typedef struct packed {
                logic        psr;
                logic        wim;
                logic        tbr;
                logic [12:0] imm;
        } csrWriteT;
endpackage

//--- files.f
+incdir+verification
common/cuPkg.sv
rtl/handshakeMaster.sv
rtl/decode/instrDecode.sv
rtl/csrFile.sv
rtl/sequencer/sequencer.sv
rtl/sparcControl.sv
verification/tbSparcControl.sv

//--- rtl/csrFile.sv
/*
 * State registers: icc, CWP, WIM and trap base, written from the
 * instruction immediate, with the SAVE/RESTORE window fault check.
 */
`timescale 1ns/1ps

module csrFile (
        input  logic            Clk,
        input  logic            rst,
        input  cuPkg::csrWriteT csrWr,
        input  logic            cwpDec,
        input  logic            cwpInc,
        input  logic            trapEnter,
        output cuPkg::iccT      icc,
        output cuPkg::cwpT      cwp,
        output logic [12:0]     trapBase,
        output logic            winOver,
        output logic            winUnder
);
        import cuPkg::*;

        logic [NumWindows-1:0] wim;
        cwpT                   cwpDown;
        cwpT                   cwpUp;

        assign cwpDown  = cwp - 1'b1;   // wraps modulo NumWindows
        assign cwpUp    = cwp + 1'b1;
        assign winOver  = wim[cwpDown];
        assign winUnder = wim[cwpUp];

        always_ff @(posedge Clk)
        begin
                if (rst)
                begin
                        icc      <= '0;
                        cwp      <= '0;
                        wim      <= '0;
                        trapBase <= '0;
                end
                else
                begin
                        if (csrWr.psr)
                        begin
                                icc <= iccT'(csrWr.imm[7:4]);
                                cwp <= csrWr.imm[2:0];
                        end
                        else if (cwpDec || trapEnter)
                                cwp <= cwpDown;         // save or trap entry
                        else if (cwpInc)
                                cwp <= cwpUp;           // restore

                        if (csrWr.wim)
                                wim <= csrWr.imm[NumWindows-1:0];
                        if (csrWr.tbr)
                                trapBase <= csrWr.imm;
                end
        end

        // the sequencer issues at most one window move per instruction
        oneWindowMove: assert property (@(posedge Clk) disable iff (rst)
                $onehot0({cwpDec, cwpInc, trapEnter}));
endmodule

//--- rtl/decode/instrDecode.sv
/*
 * Instruction decoder. Sorts a word into its control class, picks
 * the displacement and tests the cond field against icc.
 */
`timescale 1ns/1ps

module instrDecode (
        input  logic [cuPkg::DataWidth-1:0] instr,
        input  cuPkg::iccT                  icc,
        output cuPkg::decodedT              dec
);
        import cuPkg::*;

        logic [1:0] op;
        logic [2:0] op2;
        logic [5:0] op3;
        logic [3:0] cond;
        logic       iBit;
        logic       condBase;
        logic       condMet;

        assign op   = instr[31:30];
        assign op2  = instr[24:22];
        assign op3  = instr[24:19];
        assign cond = instr[28:25];
        assign iBit = instr[13];

        // low three bits pick the test, bit 3 takes the complement
        always_comb
        begin
                case (cond[2:0])
                3'd0: condBase = 1'b0;                       // never
                3'd1: condBase = icc.z;                      // equal
                3'd2: condBase = icc.z | (icc.n ^ icc.v);    // le
                3'd3: condBase = icc.n ^ icc.v;              // lt
                3'd4: condBase = icc.c | icc.z;              // leu
                3'd5: condBase = icc.c;                      // cs
                3'd6: condBase = icc.n;                      // neg
                default: condBase = icc.v;                   // vs
                endcase
                condMet = condBase ^ cond[3];
        end

        always_comb
        begin
                dec.instrClass = Illegal;
                dec.condTrue   = 1'b0;
                dec.disp       = '0;
                dec.imm        = instr[12:0];
                case (op)
                OpBranch:
                        if (op2 == Op2Bicc)
                        begin
                                dec.instrClass = Branch;
                                dec.condTrue   = condMet;
                                dec.disp       = {{8{instr[21]}}, instr[21:0]}; // disp22
                        end
                OpCall:
                begin
                        dec.instrClass = Call;
                        dec.condTrue   = 1'b1;  // always transfers
                        dec.disp       = instr[29:0];
                end
                OpArith:
                        case (op3)
                        Op3Save:    dec.instrClass = Save;
                        Op3Restore: dec.instrClass = Restore;
                        Op3Ticc:
                        begin
                                dec.instrClass = Ticc;
                                dec.condTrue   = condMet;
                        end
                        Op3WrPsr:   dec.instrClass = iBit ? WrPsr : Illegal;
                        Op3WrWim:   dec.instrClass = iBit ? WrWim : Illegal;
                        Op3WrTbr:   dec.instrClass = iBit ? WrTbr : Illegal;
                        default:    dec.instrClass = Illegal;
                        endcase
                default:
                        dec.instrClass = Illegal; // loads and stores
                endcase
        end
endmodule

//--- rtl/handshakeMaster.sv
/*
 * Four-phase req/ack requester. Latches a payload on start and
 * holds it on data until the handshake returns to idle.
 */
`timescale 1ns/1ps

module handshakeMaster #(
        parameter type payloadT = logic [31:0]
) (
        input  logic    Clk,
        input  logic    rst,
        input  logic    start,
        input  payloadT payload,
        output logic    req,
        output payloadT data,
        input  logic    ack,
        output logic    done
);
        typedef enum logic [1:0] {Idle, ReqHigh, AckLow} hsStateT;

        hsStateT state;

        assign req  = (state == ReqHigh);
        assign done = (state == AckLow) && !ack; // one cycle, ack seen low

        always_ff @(posedge Clk)
        begin
                if (rst)
                        state <= Idle;
                else
                begin
                        case (state)
                        Idle:
                                if (start)
                                        state <= ReqHigh;
                        ReqHigh:
                                if (ack)
                                        state <= AckLow;
                        AckLow:
                                if (!ack)
                                        state <= Idle;
                        default:
                                state <= Idle;
                        endcase
                end
        end

        always_ff @(posedge Clk)
        begin
                if (start && state == Idle)
                        data <= payload;
        end

        reqHeldUntilAck: assert property (@(posedge Clk) disable iff (rst)
                req && !ack |=> req);

        // the sequencer must wait for done before the next start
        noStartWhileBusy: assert property (@(posedge Clk) disable iff (rst)
                start |-> state == Idle);
endmodule

//--- rtl/sequencer/sequencer.sv
/*
 * Instruction-cycle FSM. Holds PC and IR, executes control transfers,
 * window moves and state writes, and builds the retire record.
 */
`timescale 1ns/1ps

module sequencer (
        input  logic                        Clk,
        input  logic                        rst,
        output logic                        fetchStart,
        output logic [cuPkg::AddrWidth-1:0] fetchAddr,
        input  logic                        fetchDone,
        input  logic [cuPkg::DataWidth-1:0] memData,
        output logic [cuPkg::DataWidth-1:0] instr,
        input  cuPkg::decodedT              dec,
        output cuPkg::csrWriteT             csrWr,
        output logic                        cwpDec,
        output logic                        cwpInc,
        output logic                        trapEnter,
        input  cuPkg::cwpT                  cwp,
        input  logic [12:0]                 trapBase,
        input  logic                        winOver,
        input  logic                        winUnder,
        output logic                        retireStart,
        output cuPkg::retireT               retRecord,
        input  logic                        retireDone
);
        import cuPkg::*;

        typedef enum logic [1:0] {Fetch, Decode, Execute, Retire} seqStateT;

        seqStateT             state;
        logic                 sent;     // request already issued this phase
        logic                 exec;
        logic                 transfer;
        logic [AddrWidth-1:0] pc;
        logic [AddrWidth-1:0] target;
        logic [AddrWidth-1:0] nextPc;
        trapT                 tt;
        cwpT                  cwpAfter;

        assign exec        = (state == Execute);
        assign fetchStart  = (state == Fetch) && !sent;
        assign retireStart = (state == Retire) && !sent;
        assign fetchAddr   = pc;
        assign target      = pc + {dec.disp, 2'b00};
        assign transfer    = dec.condTrue && (dec.instrClass inside {Branch, Call});

        always_comb
        begin
                tt        = TtNone;
                cwpDec    = 1'b0;
                cwpInc    = 1'b0;
                csrWr     = '0;
                csrWr.imm = dec.imm;
                case (dec.instrClass)
                Branch, Call:
                        if (transfer && target > AddrLimit)
                                tt = TtAddr;
                Ticc:
                        if (dec.condTrue)
                                tt = TtTicc + trapT'(dec.imm[6:0]);
                Save:
                        if (winOver)
                                tt = TtWinOver;
                        else
                                cwpDec = exec;
                Restore:
                        if (winUnder)
                                tt = TtWinUnder;
                        else
                                cwpInc = exec;
                WrPsr:   csrWr.psr = exec;
                WrWim:   csrWr.wim = exec;
                WrTbr:   csrWr.tbr = exec;
                default: tt = TtIllegal;
                endcase
                trapEnter = exec && (tt != TtNone);
        end

        always_comb
        begin
                if (tt != TtNone)
                        nextPc = AddrWidth'({trapBase, tt, 4'h0}); // tbr*4096 + tt*16
                else if (transfer)
                        nextPc = target;
                else
                        nextPc = pc + 32'd4;

                if (tt != TtNone || dec.instrClass == Save)
                        cwpAfter = cwp - 1'b1;
                else if (dec.instrClass == Restore)
                        cwpAfter = cwp + 1'b1;
                else if (dec.instrClass == WrPsr)
                        cwpAfter = dec.imm[2:0];
                else
                        cwpAfter = cwp;
        end

        always_ff @(posedge Clk)
        begin
                if (rst)
                begin
                        state <= Fetch;
                        sent  <= 1'b0;
                        pc    <= '0;
                end
                else
                begin
                        case (state)
                        Fetch:
                        begin
                                sent <= !fetchDone;
                                if (fetchDone)
                                        state <= Decode;
                        end
                        Decode:
                                state <= Execute;   // decoder settles on new IR
                        Execute:
                        begin
                                pc    <= nextPc;
                                state <= Retire;
                        end
                        default:
                        begin
                                sent <= !retireDone;
                                if (retireDone)
                                        state <= Fetch;
                        end
                        endcase
                end
        end

        always_ff @(posedge Clk)
        begin
                if (state == Fetch && fetchDone)
                        instr <= memData;
                if (exec)
                        retRecord <= '{pc: pc, instrClass: dec.instrClass,
                                       taken: dec.condTrue, tt: tt, cwp: cwpAfter};
        end
endmodule

//--- rtl/sparcControl.sv
/*
 * SPARC-style control unit top. Sequencer, decoder and state
 * registers behind a fetch port and a retire port.
 */
`timescale 1ns/1ps

module sparcControl (
        input  logic                        Clk,
        input  logic                        rst,
        output logic                        memReq,
        output logic [cuPkg::AddrWidth-1:0] memAddr,
        input  logic                        memAck,
        input  logic [cuPkg::DataWidth-1:0] memData,
        output logic                        retReq,
        output cuPkg::retireT               retData,
        input  logic                        retAck
);
        import cuPkg::*;

        logic                 fetchStart;
        logic                 fetchDone;
        logic [AddrWidth-1:0] fetchAddr;
        logic                 retireStart;
        logic                 retireDone;
        retireT               retRecord;
        logic [DataWidth-1:0] instr;
        decodedT              dec;
        csrWriteT             csrWr;
        logic                 cwpDec;
        logic                 cwpInc;
        logic                 trapEnter;
        iccT                  icc;
        cwpT                  cwp;
        logic [12:0]          trapBase;
        logic                 winOver;
        logic                 winUnder;

        sequencer u_sequencer (
                .Clk(Clk), .rst(rst),
                .fetchStart(fetchStart), .fetchAddr(fetchAddr), .fetchDone(fetchDone),
                .memData(memData), .instr(instr), .dec(dec),
                .csrWr(csrWr), .cwpDec(cwpDec), .cwpInc(cwpInc), .trapEnter(trapEnter),
                .cwp(cwp), .trapBase(trapBase), .winOver(winOver), .winUnder(winUnder),
                .retireStart(retireStart), .retRecord(retRecord), .retireDone(retireDone)
        );

        instrDecode u_instrDecode (.instr(instr), .icc(icc), .dec(dec));

        csrFile u_csrFile (
                .Clk(Clk), .rst(rst), .csrWr(csrWr),
                .cwpDec(cwpDec), .cwpInc(cwpInc), .trapEnter(trapEnter),
                .icc(icc), .cwp(cwp), .trapBase(trapBase),
                .winOver(winOver), .winUnder(winUnder)
        );

        handshakeMaster #(.payloadT(logic [AddrWidth-1:0])) u_fetchPort (
                .Clk(Clk), .rst(rst), .start(fetchStart), .payload(fetchAddr),
                .req(memReq), .data(memAddr), .ack(memAck), .done(fetchDone)
        );

        handshakeMaster #(.payloadT(retireT)) u_retirePort (
                .Clk(Clk), .rst(rst), .start(retireStart), .payload(retRecord),
                .req(retReq), .data(retData), .ack(retAck), .done(retireDone)
        );
endmodule

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
        --top-module tbSparcControl -Mdir obj_dir
if [ $? -ne 0 ]; then
        echo "verilator compile failed"
        exit 1
fi

out=$(./obj_dir/VtbSparcControl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if echo "$out" | grep -q "^ALL CHECKS PASSED$"; then
        exit 0
fi
exit 1

//--- verification/cuModel.svh
/*
 * Reference model of the control unit. Holds PC, icc, CWP, WIM and
 * trap base, predicts the retire record of one instruction word.
 */
`ifndef CU_MODEL_SVH
`define CU_MODEL_SVH

logic [AddrWidth-1:0] mPc;
iccT                  mIcc;
cwpT                  mCwp;
logic [7:0]           mWim;
logic [12:0]          mTbr;

task automatic resetModel();
        mPc  = '0;
        mIcc = '0;
        mCwp = '0;
        mWim = '0;
        mTbr = '0;
endtask

// the sixteen SPARC integer conditions, in cond field order
function automatic logic condHolds(input logic [3:0] cond, input iccT f);
        case (cond)
        4'h0:    return 1'b0;                        // bn
        4'h1:    return f.z;                         // be
        4'h2:    return f.z | (f.n ^ f.v);           // ble
        4'h3:    return f.n ^ f.v;                   // bl
        4'h4:    return f.c | f.z;                   // bleu
        4'h5:    return f.c;                         // bcs
        4'h6:    return f.n;                         // bneg
        4'h7:    return f.v;                         // bvs
        4'h8:    return 1'b1;                        // ba
        4'h9:    return !f.z;                        // bne
        4'hA:    return !(f.z | (f.n ^ f.v));        // bg
        4'hB:    return !(f.n ^ f.v);                // bge
        4'hC:    return !(f.c | f.z);                // bgu
        4'hD:    return !f.c;                        // bcc
        4'hE:    return !f.n;                        // bpos
        default: return !f.v;                        // bvc
        endcase
endfunction

task automatic predictRetire(input logic [DataWidth-1:0] w, output retireT r);
        logic [AddrWidth-1:0] off;
        logic [AddrWidth-1:0] tgt;
        logic [AddrWidth-1:0] next;
        logic                 cnd;
        cwpT                  below;
        cwpT                  above;
        cnd           = condHolds(w[28:25], mIcc);
        off           = '0;
        below         = mCwp - 3'd1;
        above         = mCwp + 3'd1;
        r.pc          = mPc;
        r.instrClass  = Illegal;
        r.taken       = 1'b0;
        r.tt          = TtNone;
        case (w[31:30])
        2'd0:
                if (w[24:22] == 3'd2)
                begin
                        r.instrClass = Branch;
                        r.taken      = cnd;
                        off          = {{8{w[21]}}, w[21:0], 2'b00};
                end
        2'd1:
        begin
                r.instrClass = Call;
                r.taken      = 1'b1;
                off          = {w[29:0], 2'b00};
        end
        2'd2:
                case (w[24:19])
                6'h3C:   r.instrClass = Save;
                6'h3D:   r.instrClass = Restore;
                6'h3A:
                begin
                        r.instrClass = Ticc;
                        r.taken      = cnd;
                end
                6'h31:   r.instrClass = w[13] ? WrPsr : Illegal;
                6'h32:   r.instrClass = w[13] ? WrWim : Illegal;
                6'h33:   r.instrClass = w[13] ? WrTbr : Illegal;
                default: r.instrClass = Illegal;
                endcase
        default:
                r.instrClass = Illegal;
        endcase

        tgt  = mPc + off;
        next = mPc + 32'd4;
        case (r.instrClass)
        Branch, Call:
                if (r.taken && tgt > AddrLimit)
                        r.tt = TtAddr;
                else if (r.taken)
                        next = tgt;
        Ticc:
                if (r.taken)
                        r.tt = TtTicc + {1'b0, w[6:0]};
        Save:
                if (mWim[below])
                        r.tt = TtWinOver;
                else
                        mCwp = below;
        Restore:
                if (mWim[above])
                        r.tt = TtWinUnder;
                else
                        mCwp = above;
        WrPsr:
        begin
                mIcc = iccT'(w[7:4]);
                mCwp = w[2:0];
        end
        WrWim:   mWim = w[7:0];
        WrTbr:   mTbr = w[12:0];
        default: r.tt = TtIllegal;
        endcase

        if (r.tt != TtNone)
        begin
                next = 32'(mTbr) * 4096 + 32'(r.tt) * 16;   // trap vector
                mCwp = below;
        end
        mPc   = next;
        r.cwp = mCwp;
endtask

`endif

//--- verification/tbSparcControl.sv
/*
 * Testbench for the control unit. Serves fetches from a random program
 * image, accepts retire records and checks them against the model.
 */
`timescale 1ns/1ps

module tbSparcControl;
        import cuPkg::*;

        localparam int NumInstr  = 300;
        localparam int WaitLimit = 200;

        logic                 Clk;
        logic                 rst;
        logic                 memReq;
        logic [AddrWidth-1:0] memAddr;
        logic                 memAck;
        logic [DataWidth-1:0] memData;
        logic                 retReq;
        retireT               retData;
        logic                 retAck;

        integer               seed;
        int                   errCount;
        int                   timeoutCount;
        int                   retired;
        bit                   ok;
        logic [DataWidth-1:0] fetched;
        logic [DataWidth-1:0] image [0:255];

        `include "cuModel.svh"

        sparcControl u_sparcControl (
                .Clk(Clk), .rst(rst),
                .memReq(memReq), .memAddr(memAddr), .memAck(memAck), .memData(memData),
                .retReq(retReq), .retData(retData), .retAck(retAck)
        );

        always #50 Clk = ~Clk;

        task automatic stepCycle();
                @(posedge Clk);
                #10;
        endtask

        function automatic int randBelow(input int n);
                return int'($unsigned($random(seed)) % n);
        endfunction

        // biased toward legal control words with small displacements
        function automatic logic [DataWidth-1:0] genWord();
                logic [31:0] r;
                int          d;
                logic        iBit;
                r    = $random(seed);
                d    = randBelow(256) - 128;
                iBit = randBelow(8) != 0;
                case (randBelow(16))
                0, 1, 2, 3: return {2'b00, 1'b0, r[28:25], Op2Bicc, d[21:0]};
                4:          return {2'b01, d[29:0]};
                5:          return {2'b10, r[29:25], Op3Save, r[18:0]};
                6:          return {2'b10, r[29:25], Op3Restore, r[18:0]};
                7, 8:       return {2'b10, 1'b0, r[28:25], Op3Ticc, r[18:14], 1'b1, r[12:0]};
                9, 10:      return {2'b10, r[29:25], Op3WrPsr, r[18:14], iBit, r[12:0]};
                11:         return {2'b10, r[29:25], Op3WrWim, r[18:14], iBit, r[12:8],
                                    r[7:0] & r[31:24]};   // sparse mask
                12:         return {2'b10, r[29:25], Op3WrTbr, r[18:14], iBit, 11'd0, r[1:0]};
                default:    return r;                      // mostly illegal
                endcase
        endfunction

        // folds every address bit into the image slot
        function automatic int imageIndex(input logic [AddrWidth-1:0] a);
                logic [7:0] h;
                h = a[9:2] ^ a[17:10] ^ a[25:18] ^ {2'b00, a[31:26]} ^ {6'd0, a[1:0]};
                return int'(h);
        endfunction

        task automatic checkPc(input string name, input logic [DataWidth-1:0] got,
                               input logic [DataWidth-1:0] exp);
                if (got !== exp)
                begin
                        errCount++;
                        $display("ERR %s got %h exp %h", name, got, exp);
                end
        endtask

        task automatic checkClass(input string name, input instrClassT got, input instrClassT exp);
                if (got !== exp)
                begin
                        errCount++;
                        $display("ERR %s got %h exp %h", name, got, exp);
                end
        endtask

        task automatic checkTrap(input string name, input trapT got, input trapT exp);
                if (got !== exp)
                begin
                        errCount++;
                        $display("ERR %s got %h exp %h", name, got, exp);
                end
        endtask

        task automatic checkCwp(input string name, input cwpT got, input cwpT exp);
                if (got !== exp)
                begin
                        errCount++;
                        $display("ERR %s got %h exp %h", name, got, exp);
                end
        endtask

        task automatic checkFlag(input string name, input logic got, input logic exp);
                if (got !== exp)
                begin
                        errCount++;
                        $display("ERR %s got %h exp %h", name, got, exp);
                end
        endtask

        task automatic waitMemReq(input logic level, output bit done);
                int n;
                n = 0;
                while (memReq !== level && n < WaitLimit)
                begin
                        if (level && retReq)
                        begin
                                errCount++;
                                $display("retire request seen while a fetch was expected");
                        end
                        stepCycle();
                        n++;
                end
                done = (memReq === level);
                if (!done)
                begin
                        timeoutCount++;
                        $display("timeout waiting for memReq to reach %0d", level);
                end
        endtask

        task automatic waitRetReq(input logic level, output bit done);
                int n;
                n = 0;
                while (retReq !== level && n < WaitLimit)
                begin
                        if (level && memReq)
                        begin
                                errCount++;
                                $display("fetch request seen before the retire");
                        end
                        stepCycle();
                        n++;
                end
                done = (retReq === level);
                if (!done)
                begin
                        timeoutCount++;
                        $display("timeout waiting for retReq to reach %0d", level);
                end
        endtask

        task automatic serveFetch(output bit done);
                logic [AddrWidth-1:0] addr;
                int                   slot;
                int                   delay;
                waitMemReq(1'b1, done);
                if (done)
                begin
                        addr    = memAddr;
                        checkPc("memAddr", addr, mPc);
                        slot    = imageIndex(addr);
                        fetched = image[slot];
                        delay   = randBelow(4);
                        repeat (delay)
                        begin
                                stepCycle();
                                if (memReq !== 1'b1 || memAddr !== addr)
                                begin
                                        errCount++;
                                        $display("memReq or memAddr changed before memAck");
                                end
                        end
                        memData = fetched;       // held until the next request
                        memAck  = 1'b1;
                        waitMemReq(1'b0, done);
                        memAck  = 1'b0;
                        image[slot] = genWord(); // keeps trap vectors from looping
                end
        endtask

        task automatic acceptRetire(output bit done);
                retireT rec;
                retireT exp;
                int     delay;
                waitRetReq(1'b1, done);
                if (done)
                begin
                        rec   = retData;
                        delay = randBelow(4);
                        repeat (delay)
                        begin
                                stepCycle();
                                if (retReq !== 1'b1 || retData !== rec)
                                begin
                                        errCount++;
                                        $display("retReq or retData changed before retAck");
                                end
                        end
                        retAck = 1'b1;
                        waitRetReq(1'b0, done);
                        retAck = 1'b0;
                        predictRetire(fetched, exp);
                        checkPc("retData.pc", rec.pc, exp.pc);
                        checkClass("retData.instrClass", rec.instrClass, exp.instrClass);
                        checkFlag("retData.taken", rec.taken, exp.taken);
                        checkTrap("retData.tt", rec.tt, exp.tt);
                        checkCwp("retData.cwp", rec.cwp, exp.cwp);
                        retired++;
                end
        endtask

        initial
        begin
                Clk          = 1'b0;
                rst          = 1'b1;
                memAck       = 1'b0;
                memData      = '0;
                retAck       = 1'b0;
                seed         = 32'ha5736fdb;
                errCount     = 0;
                timeoutCount = 0;
                retired      = 0;
                ok           = 1'b1;
                for (int i = 0; i < 256; i++)
                        image[i] = genWord();
                resetModel();
                repeat (4) @(posedge Clk);
                #10;
                rst = 1'b0;

                while (ok && retired < NumInstr)
                begin
                        serveFetch(ok);
                        if (ok)
                                acceptRetire(ok);
                end

                $display("retired %0d  errors %0d  timeouts %0d", retired, errCount, timeoutCount);
                if (errCount == 0 && timeoutCount == 0 && retired == NumInstr)
                        $display("ALL CHECKS PASSED");
                else
                        $display("CHECKS FAILED");
                $finish;
        end
endmodule
